//--- source/fetch_macros.svh
/* Build-time settings of the fetch stage: boot address, queue size and memory byte order.
   Included by the modules that need them. */
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// first pc after reset
`define FETCH_BOOT_PC 32'h0000_0000

// queue holds 2**4 = 16 entries
`define FETCH_QUEUE_DEPTH_LOG2 4

// almost full once count reaches depth minus this margin
`define FETCH_QUEUE_MARGIN 2

// 1 when memory words are little-endian and must be swapped on output
`define FETCH_MEM_LITTLE_ENDIAN 1

`endif

//--- source/fetch_pkg.sv
/* Shared types, instruction encodings and the byte-swap helper for the fetch stage.
   Modules import it inside their body and use scoped names on their ports. */
`default_nettype none

package fetch_pkg;

	typedef logic [31:0] data_t;
	typedef logic [31:0] instr_t;

	// one queue slot, the word as read from memory plus its address
	typedef struct packed {
		instr_t instr;
		data_t  pc;
	} fetch_entry_t;

	// AXI-Lite read address channel payload
	typedef struct packed {
		data_t      araddr;
		logic [2:0] arprot;
	} axil_ar_t;

	// AXI-Lite read data channel payload
	typedef struct packed {
		data_t      rdata;
		logic [1:0] rresp;
	} axil_r_t;

	typedef enum logic [1:0] {
		IDLE,
		FETCH,
		FULL_WAIT,
		ECALL_WAIT
	} fetch_state_t;

	localparam instr_t INSTR_ECALL = 32'h0000_0073;
	// addi x0, x0, 0
	localparam instr_t INSTR_NOP   = 32'h0000_0013;

	// unprivileged, secure, instruction access
	localparam logic [2:0] ARPROT_INSTR = 3'b100;

	function automatic data_t swap_bytes(input data_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

endpackage

`default_nettype wire

//--- source/axil_read_master.sv
/* AXI-Lite read master: turns a read request into one address and one data transfer,
   then pulses done with the returned word. */
`timescale 1ns/1ps
`default_nettype none

module axil_read_master (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               rd_req,
	input  fetch_pkg::data_t   addr,
	input  logic               ar_ready,
	input  logic               r_valid,
	input  fetch_pkg::axil_r_t r,
	output fetch_pkg::axil_ar_t ar,
	output logic               ar_valid,
	output logic               r_ready,
	output logic               done,
	output fetch_pkg::data_t   rdata
);
	import fetch_pkg::*;

	typedef enum logic [1:0] {
		PH_IDLE,
		PH_ADDR,
		PH_DATA
	} phase_t;

	phase_t phase;
	data_t  araddr_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= PH_IDLE;
		end else begin
			unique case (phase)
				PH_IDLE: if (rd_req) phase <= PH_ADDR;
				PH_ADDR: if (ar_ready) phase <= PH_DATA;
				PH_DATA: if (r_valid) phase <= PH_IDLE;
				default: phase <= PH_IDLE;
			endcase
		end
	end

	// address is captured once and held until the handshake
	always_ff @(posedge clk) begin
		if (phase == PH_IDLE && rd_req) begin
			araddr_q <= addr;
		end
	end

	assign ar_valid = (phase == PH_ADDR);
	assign ar       = '{araddr: araddr_q, arprot: ARPROT_INSTR};

	// ready only once the address has gone out
	assign r_ready  = (phase == PH_DATA);
	assign done     = r_ready && r_valid;

	// rresp is not checked
	assign rdata    = r.rdata;

endmodule

`default_nettype wire

//--- source/instr_queue.sv
/* Circular FIFO for fetched entries, with any entry type.
   Reports empty, almost full and the current fill count; clear drops all entries. */
`timescale 1ns/1ps
`default_nettype none

module instr_queue #(
	parameter type ENTRY_T    = logic [63:0],
	parameter int  DEPTH_LOG2 = 4,
	parameter int  MARGIN     = 2
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                clear,
	input  logic                push,
	input  logic                pop,
	input  ENTRY_T              push_entry,
	output ENTRY_T              head,
	output logic                empty,
	output logic                almost_full,
	output logic [DEPTH_LOG2:0] count
);

	localparam int DEPTH = 1 << DEPTH_LOG2;

	ENTRY_T                mem [DEPTH];
	logic [DEPTH_LOG2-1:0] wr_ptr;
	logic [DEPTH_LOG2-1:0] rd_ptr;
	logic                  full;
	logic                  do_push;
	logic                  do_pop;

	assign full    = (count == (DEPTH_LOG2+1)'(DEPTH));
	assign empty   = (count == '0);
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) wr_ptr <= wr_ptr + 1'b1;
			if (do_pop) rd_ptr <= rd_ptr + 1'b1;
			count <= count + (DEPTH_LOG2+1)'(do_push) - (DEPTH_LOG2+1)'(do_pop);
		end
	end

	always_ff @(posedge clk) begin
		if (do_push && !clear) begin
			mem[wr_ptr] <= push_entry;
		end
	end

	assign head        = mem[rd_ptr];
	assign almost_full = (count >= (DEPTH_LOG2+1)'(DEPTH - MARGIN));

endmodule

`default_nettype wire

//--- source/fetch_ctrl.sv
/* Fetch controller: state machine, pc and flush target, read requests and queue pushes.
   Also drives the decode-side outputs from the queue head. */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_ctrl (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    go,
	input  logic                    flush,
	input  logic                    stall,
	input  logic                    done,
	input  logic                    empty,
	input  logic                    almost_full,
	input  fetch_pkg::data_t        pc_bj,
	input  fetch_pkg::data_t        rdata,
	input  fetch_pkg::instr_t       instr_w,
	input  fetch_pkg::fetch_entry_t head,
	output logic                    rd_req,
	output logic                    push,
	output logic                    pop,
	output logic                    clear,
	output fetch_pkg::data_t        addr,
	output fetch_pkg::fetch_entry_t push_entry,
	output fetch_pkg::data_t        pc_out,
	output fetch_pkg::instr_t       instr,
	output logic                    instr_valid
);
	import fetch_pkg::*;

	localparam bit SWAP = (`FETCH_MEM_LITTLE_ENDIAN != 0);

	fetch_state_t state;
	fetch_state_t state_nxt;
	data_t        pc;
	data_t        bj_q;
	logic         flush_pend;
	logic         rd_busy;
	instr_t       rd_instr;
	instr_t       head_instr;
	logic         is_ecall;

	// memory words in instruction byte order
	assign rd_instr   = SWAP ? swap_bytes(rdata) : rdata;
	assign head_instr = SWAP ? swap_bytes(head.instr) : head.instr;
	assign is_ecall   = (rd_instr == INSTR_ECALL);

	// a word that returns after a flush belongs to the old path
	assign push       = done && !flush && !flush_pend;
	assign push_entry = '{instr: rdata, pc: pc};
	assign clear      = flush;

	// one read at a time, none while the queue is nearly full
	assign rd_req = (state == FETCH) && !rd_busy && !almost_full && !flush;
	assign addr   = pc;

	// mirrors the read master, busy from request to done
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_busy <= 1'b0;
		end else if (rd_req) begin
			rd_busy <= 1'b1;
		end else if (done) begin
			rd_busy <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flush_pend <= 1'b0;
		end else if (done) begin
			flush_pend <= 1'b0;
		end else if (flush && rd_busy) begin
			flush_pend <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (flush) begin
			bj_q <= pc_bj;
		end
	end

	// redirect at once when nothing is in flight, else at the stale done
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= `FETCH_BOOT_PC;
		end else if (flush && (!rd_busy || done)) begin
			pc <= pc_bj;
		end else if (done) begin
			pc <= flush_pend ? bj_q : pc + 32'd4;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		unique case (state)
			IDLE: begin
				if (go) state_nxt = FETCH;
			end
			FETCH: begin
				// ecall wins, no more reads follow it
				if (push && is_ecall) begin
					state_nxt = ECALL_WAIT;
				end else if (almost_full && !rd_busy) begin
					state_nxt = FULL_WAIT;
				end
			end
			FULL_WAIT: begin
				if (!almost_full) state_nxt = FETCH;
			end
			ECALL_WAIT: begin
				// hold until the ecall has been written back
				if (instr_w == INSTR_ECALL) state_nxt = IDLE;
			end
			default: state_nxt = IDLE;
		endcase
	end

	// decode side
	assign instr_valid = !empty && !stall && !flush && !flush_pend;
	assign pop         = instr_valid;
	assign instr       = instr_valid ? head_instr : INSTR_NOP;
	assign pc_out      = instr_valid ? head.pc : '0;

endmodule

`default_nettype wire

//--- source/fetch_top.sv
/* Instruction fetch stage top: controller, AXI-Lite read master and instruction queue.
   Connect the read channel to instruction memory and the outputs to decode. */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                go,
	input  logic                flush,
	input  logic                stall,
	input  fetch_pkg::data_t    pc_bj,
	input  fetch_pkg::instr_t   instr_w,
	input  logic                ar_ready,
	input  logic                r_valid,
	input  fetch_pkg::axil_r_t  r,
	output fetch_pkg::data_t    pc_out,
	output fetch_pkg::instr_t   instr,
	output logic                instr_valid,
	output fetch_pkg::axil_ar_t ar,
	output logic                ar_valid,
	output logic                r_ready
);
	import fetch_pkg::*;

	logic         rd_req;
	logic         done;
	logic         push;
	logic         pop;
	logic         clear;
	logic         empty;
	logic         almost_full;
	data_t        addr;
	data_t        rdata;
	fetch_entry_t push_entry;
	fetch_entry_t head;

	fetch_ctrl fetch_ctrl_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.go          (go),
		.flush       (flush),
		.stall       (stall),
		.done        (done),
		.empty       (empty),
		.almost_full (almost_full),
		.pc_bj       (pc_bj),
		.rdata       (rdata),
		.instr_w     (instr_w),
		.head        (head),
		.rd_req      (rd_req),
		.push        (push),
		.pop         (pop),
		.clear       (clear),
		.addr        (addr),
		.push_entry  (push_entry),
		.pc_out      (pc_out),
		.instr       (instr),
		.instr_valid (instr_valid)
	);

	axil_read_master axil_read_master_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd_req   (rd_req),
		.addr     (addr),
		.ar_ready (ar_ready),
		.r_valid  (r_valid),
		.r        (r),
		.ar       (ar),
		.ar_valid (ar_valid),
		.r_ready  (r_ready),
		.done     (done),
		.rdata    (rdata)
	);

	// fill count is left open, the controller only needs the flags
	instr_queue #(
		.ENTRY_T    (fetch_entry_t),
		.DEPTH_LOG2 (`FETCH_QUEUE_DEPTH_LOG2),
		.MARGIN     (`FETCH_QUEUE_MARGIN)
	) instr_queue_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.clear       (clear),
		.push        (push),
		.pop         (pop),
		.push_entry  (push_entry),
		.head        (head),
		.empty       (empty),
		.almost_full (almost_full),
		.count       ()
	);

endmodule

`default_nettype wire

//--- verif/axil_mem_model.sv
/* AXI-Lite read slave for simulation, a word array answered after random delays.
   The testbench loads the array through a hierarchical path before reset ends. */
`timescale 1ns/1ps
`default_nettype none

module axil_mem_model #(
	parameter int WORDS_LOG2 = 10
) (
	input  logic                clk,
	input  logic                rst_n,
	input  fetch_pkg::axil_ar_t ar,
	input  logic                ar_valid,
	output logic                ar_ready,
	output fetch_pkg::axil_r_t  r,
	output logic                r_valid,
	input  logic                r_ready
);
	import fetch_pkg::*;

	data_t                 mem [1 << WORDS_LOG2];
	logic [WORDS_LOG2-1:0] idx_q;
	logic                  pending;
	logic [1:0]            ar_wait;
	logic [1:0]            r_wait;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ar_ready <= 1'b0;
			r_valid  <= 1'b0;
			r        <= '0;
			pending  <= 1'b0;
			idx_q    <= '0;
			ar_wait  <= '0;
			r_wait   <= '0;
		end else begin
			ar_ready <= 1'b0;
			// accept a new address only when no response is owed
			if (ar_valid && !ar_ready && !pending && !r_valid) begin
				if (ar_wait == 2'd0) begin
					ar_ready <= 1'b1;
					ar_wait  <= 2'($urandom_range(2));
				end else begin
					ar_wait <= ar_wait - 2'd1;
				end
			end
			if (ar_valid && ar_ready) begin
				pending <= 1'b1;
				idx_q   <= ar.araddr[WORDS_LOG2+1:2];
				r_wait  <= 2'($urandom_range(3));
			end
			if (pending && !r_valid) begin
				if (r_wait == 2'd0) begin
					r_valid <= 1'b1;
					r       <= '{rdata: mem[idx_q], rresp: 2'b00};
					pending <= 1'b0;
				end else begin
					r_wait <= r_wait - 2'd1;
				end
			end
			// response held until the master takes it
			if (r_valid && r_ready) begin
				r_valid <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- verif/fetch_checker.sv
/* Bus and output rules of the fetch stage as concurrent assertions.
   Bound into fetch_top; fail_total counts every assertion failure. */
`timescale 1ns/1ps
`default_nettype none

module fetch_checker (
	input logic                clk,
	input logic                rst_n,
	input fetch_pkg::axil_ar_t ar,
	input logic                ar_valid,
	input logic                ar_ready,
	input logic                stall,
	input logic                instr_valid
);

	int fails_ar    = 0;
	int fails_stall = 0;
	int fails_reset = 0;
	int fail_total;

	assign fail_total = fails_ar + fails_stall + fails_reset;

	// a pending address keeps valid high and its payload unchanged
	ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar))
	else begin
		fails_ar = fails_ar + 1;
		$error("ar dropped or changed before its handshake");
	end

	stall_blocks: assert property (@(posedge clk) disable iff (!rst_n)
		stall |-> !instr_valid)
	else begin
		fails_stall = fails_stall + 1;
		$error("instr_valid high while stall is high");
	end

	// first cycle out of reset
	reset_quiet: assert property (@(posedge clk) $rose(rst_n) |-> !ar_valid)
	else begin
		fails_reset = fails_reset + 1;
		$error("ar_valid high right after reset release");
	end

endmodule

bind fetch_top fetch_checker fetch_checker_inst (
	.clk         (clk),
	.rst_n       (rst_n),
	.ar          (ar),
	.ar_valid    (ar_valid),
	.ar_ready    (ar_ready),
	.stall       (stall),
	.instr_valid (instr_valid)
);

`default_nettype wire

//--- verif/fetch_tb.sv
/* Directed testbench of the fetch stage: boot, stall, flush, ecall and byte order.
   A negedge monitor checks every delivered pair against the memory contents. */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_tb;
	import fetch_pkg::*;

	localparam int     WORDS_LOG2 = 10;
	localparam int     TIMEOUT    = 2000;
	localparam int     QUEUE_FILL = (1 << `FETCH_QUEUE_DEPTH_LOG2) - `FETCH_QUEUE_MARGIN;
	localparam instr_t ECALL      = 32'h0000_0073;

	logic     clk = 1'b0;
	logic     rst_n;
	logic     go;
	logic     flush;
	logic     stall;
	data_t    pc_bj;
	instr_t   instr_w;
	logic     ar_ready;
	logic     r_valid;
	axil_r_t  r;
	data_t    pc_out;
	instr_t   instr;
	logic     instr_valid;
	axil_ar_t ar;
	logic     ar_valid;
	logic     r_ready;

	data_t  words [1 << WORDS_LOG2];
	data_t  exp_pc = `FETCH_BOOT_PC;
	data_t  last_pc = '0;
	instr_t last_instr = '0;
	int     n_out = 0;
	int     errors = 0;
	int     tests = 0;
	int     i;

	always #4 clk = ~clk;

	fetch_top fetch_top_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.go          (go),
		.flush       (flush),
		.stall       (stall),
		.pc_bj       (pc_bj),
		.instr_w     (instr_w),
		.ar_ready    (ar_ready),
		.r_valid     (r_valid),
		.r           (r),
		.pc_out      (pc_out),
		.instr       (instr),
		.instr_valid (instr_valid),
		.ar          (ar),
		.ar_valid    (ar_valid),
		.r_ready     (r_ready)
	);

	axil_mem_model #(.WORDS_LOG2(WORDS_LOG2)) mem_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.ar       (ar),
		.ar_valid (ar_valid),
		.ar_ready (ar_ready),
		.r        (r),
		.r_valid  (r_valid),
		.r_ready  (r_ready)
	);

	// four distinct bytes that together encode the whole index
	function automatic data_t fill_word(input int idx);
		logic [7:0] low;
		logic [7:0] hi;
		low = idx[7:0];
		hi  = {6'b0, idx[9:8]};
		return {low, low ^ 8'h40 ^ hi, low ^ 8'h80 ^ hi, low ^ 8'hc0 ^ hi};
	endfunction

	// memory order to instruction order, its own inverse
	function automatic instr_t order_bytes(input data_t w);
		instr_t v;
		int     b;
		v = w;
		if (`FETCH_MEM_LITTLE_ENDIAN != 0) begin
			for (b = 0; b < 4; b++) begin
				v[8*b +: 8] = w[8*(3-b) +: 8];
			end
		end
		return v;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors = errors + 1;
			$display("mismatch %s: got %08h, expected %08h", name, got, exp);
		end
	endtask

	task automatic wait_outputs(input int count, input string what);
		int target;
		int cycles;
		target = n_out + count;
		cycles = 0;
		while (n_out < target && cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (n_out < target) begin
			errors = errors + 1;
			$display("timeout: fewer than %0d instructions arrived during %s", count, what);
		end
	endtask

	task automatic redirect(input data_t target);
		@(posedge clk);
		flush <= 1'b1;
		pc_bj <= target;
		@(posedge clk);
		flush <= 1'b0;
	endtask

	task automatic report_test(input string name, input int err0);
		tests++;
		$display("test %0d %s: %s, %0d errors", tests, name,
			(errors == err0) ? "ok" : "FAILED", errors - err0);
	endtask

	// a flush restarts the expected sequence, otherwise each valid pair is one pop
	always @(negedge clk) begin
		if (flush) begin
			exp_pc = pc_bj;
		end else if (rst_n && instr_valid) begin
			check("pc_out", pc_out, exp_pc);
			check("instr", instr, order_bytes(words[exp_pc[WORDS_LOG2+1:2]]));
			last_pc    = pc_out;
			last_instr = instr;
			exp_pc     = exp_pc + 32'd4;
			n_out      = n_out + 1;
		end
	end

	// every read is an unprivileged, secure instruction access
	always @(negedge clk) begin
		if (rst_n && ar_valid) begin
			check("arprot", 32'(ar.arprot), 32'h0000_0004);
		end
	end

	task automatic test_boot();
		int err0;
		err0 = errors;
		@(posedge clk);
		go <= 1'b1;
		@(posedge clk);
		go <= 1'b0;
		wait_outputs(24, "boot sequence");
		report_test("boot", err0);
	endtask

	task automatic test_stall();
		int err0;
		int n;
		int quiet;
		int cycles;
		err0 = errors;
		for (n = 0; n < 300; n++) begin
			@(posedge clk);
			stall <= ($urandom_range(2) == 0);
		end
		@(posedge clk);
		stall <= 1'b0;
		wait_outputs(8, "random stall");
		// hold stall until reads stop on a nearly full queue
		@(posedge clk);
		stall <= 1'b1;
		quiet = 0;
		cycles = 0;
		while (quiet < 20 && cycles < TIMEOUT) begin
			@(negedge clk);
			quiet = ar_valid ? 0 : quiet + 1;
			cycles++;
		end
		if (quiet < 20) begin
			errors = errors + 1;
			$display("reads kept starting while decode was stalled");
		end
		@(posedge clk);
		stall <= 1'b0;
		// the held words leave back to back
		for (n = 0; n < QUEUE_FILL; n++) begin
			@(negedge clk);
			check("instr_valid", 32'(instr_valid), 32'd1);
		end
		wait_outputs(4, "drain after stall");
		report_test("stall", err0);
	endtask

	task automatic test_flush();
		int err0;
		int cycles;
		err0 = errors;
		// catch a read in flight so its word must be dropped
		cycles = 0;
		while (!(ar_valid && ar_ready) && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (cycles >= TIMEOUT) begin
			errors = errors + 1;
			$display("timeout: no address handshake seen before flush");
		end
		redirect(32'h0000_0800);
		wait_outputs(1, "flush");
		check("pc_out", last_pc, 32'h0000_0800);
		wait_outputs(20, "after flush");
		report_test("flush", err0);
	endtask

	task automatic test_ecall();
		int    err0;
		int    n;
		int    cycles;
		data_t ecall_pc;
		err0 = errors;
		ecall_pc = 32'h0000_0a40;
		words[ecall_pc[WORDS_LOG2+1:2]] = order_bytes(ECALL);
		mem_inst.mem[ecall_pc[WORDS_LOG2+1:2]] = order_bytes(ECALL);
		redirect(32'h0000_0a00);
		cycles = 0;
		while (last_instr != ECALL && cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (last_instr != ECALL) begin
			errors = errors + 1;
			$display("timeout: the ecall word was never delivered");
		end
		check("pc_out", last_pc, ecall_pc);
		for (n = 0; n < 30; n++) begin
			@(negedge clk);
			check("ar_valid", 32'(ar_valid), 32'd0);
		end
		// written back, then restart
		@(posedge clk);
		instr_w <= ECALL;
		@(posedge clk);
		instr_w <= '0;
		go      <= 1'b1;
		@(posedge clk);
		go <= 1'b0;
		wait_outputs(1, "resume after ecall");
		check("pc_out", last_pc, ecall_pc + 32'd4);
		wait_outputs(10, "after ecall");
		report_test("ecall", err0);
	endtask

	task automatic test_byte_order();
		int     err0;
		data_t  byte_pc;
		data_t  stored;
		instr_t expected;
		err0 = errors;
		byte_pc  = 32'h0000_0c00;
		stored   = words[byte_pc[WORDS_LOG2+1:2]];
		expected = order_bytes(stored);
		redirect(byte_pc);
		wait_outputs(1, "byte order");
		check("pc_out", last_pc, byte_pc);
		check("instr", last_instr, expected);
		wait_outputs(6, "after byte order");
		report_test("byte_order", err0);
	endtask

	initial begin
		void'($urandom(32'h9fa7_5ce4));
		rst_n   = 1'b0;
		go      = 1'b0;
		flush   = 1'b0;
		stall   = 1'b0;
		pc_bj   = '0;
		instr_w = '0;
		for (i = 0; i < (1 << WORDS_LOG2); i++) begin
			words[10'(i)] = fill_word(i);
			mem_inst.mem[10'(i)] = fill_word(i);
		end
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		test_boot();
		test_stall();
		test_flush();
		test_ecall();
		test_byte_order();
		repeat (10) @(posedge clk);
		$display("summary: %0d tests, %0d instructions, %0d check errors, %0d assertion errors",
			tests, n_out, errors, fetch_top_inst.fetch_checker_inst.fail_total);
		if (errors == 0 && fetch_top_inst.fetch_checker_inst.fail_total == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- fetch.f
+incdir+source
source/fetch_pkg.sv
source/axil_read_master.sv
source/instr_queue.sv
source/fetch_ctrl.sv
source/fetch_top.sv
verif/axil_mem_model.sv
verif/fetch_checker.sv
verif/fetch_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := fetch_tb
FILELIST  := fetch.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SIM_ARGS  := +verilator+error+limit+100
FAIL_MSG  := Simulation failed
PASS_MSG  := Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
